// File: logic/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;

    localparam int NUM_REGS = 32;

    // R-type view of an instruction word
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        funct_t    funct;
    } rtype_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // SPECIAL function field
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

endpackage

// File: logic/id_ctrl_pkg.sv
package id_ctrl_pkg;

    typedef logic [7:0] aluop_t;
    typedef logic [2:0] alusel_t;

    // operation codes seen by EX
    localparam aluop_t ALU_NOP   = 8'b0000_0000;
    localparam aluop_t ALU_SRL   = 8'b0000_0010;
    localparam aluop_t ALU_SRA   = 8'b0000_0011;
    localparam aluop_t ALU_ADD   = 8'b0010_0000;
    localparam aluop_t ALU_ADDU  = 8'b0010_0001;
    localparam aluop_t ALU_SUB   = 8'b0010_0010;
    localparam aluop_t ALU_SUBU  = 8'b0010_0011;
    localparam aluop_t ALU_AND   = 8'b0010_0100;
    localparam aluop_t ALU_OR    = 8'b0010_0101;
    localparam aluop_t ALU_XOR   = 8'b0010_0110;
    localparam aluop_t ALU_NOR   = 8'b0010_0111;
    localparam aluop_t ALU_SLT   = 8'b0010_1010;
    localparam aluop_t ALU_SLTU  = 8'b0010_1011;
    localparam aluop_t ALU_ADDI  = 8'b0101_0101;
    localparam aluop_t ALU_ADDIU = 8'b0101_0110;
    localparam aluop_t ALU_SLL   = 8'b0111_1100;

    // result class that picks the EX result mux
    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_ARITH = 3'b100;

    // one register write from EX, MEM or writeback
    typedef struct packed {
        logic                    we;
        mips_isa_pkg::reg_addr_t addr;
        mips_isa_pkg::word_t     data;
    } wr_port_t;

    typedef struct packed {
        aluop_t                  aluop;
        alusel_t                 alusel;
        logic                    re1;
        logic                    re2;
        mips_isa_pkg::reg_addr_t raddr1;
        mips_isa_pkg::reg_addr_t raddr2;
        mips_isa_pkg::reg_addr_t wd;     // destination register
        logic                    wreg;
        mips_isa_pkg::word_t     imm;
    } id_ctrl_t;

    typedef struct packed {
        aluop_t                  aluop;
        alusel_t                 alusel;
        mips_isa_pkg::word_t     reg1;
        mips_isa_pkg::word_t     reg2;
        mips_isa_pkg::reg_addr_t wd;
        logic                    wreg;
    } id_ex_t;

endpackage

// File: logic/inst_decoder.sv
module inst_decoder (
    input  mips_isa_pkg::inst_t   inst_i,
    output id_ctrl_pkg::id_ctrl_t ctrl_o
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    rtype_t f;
    imm16_t imm16;
    word_t  imm_zext;
    word_t  imm_sext;
    logic   r_hit;      // supported register-register op
    logic   i_hit;      // supported immediate op
    logic   sh_hit;

    assign f        = inst_i;
    assign imm16    = inst_i[15:0];
    assign imm_zext = {16'h0000, imm16};
    assign imm_sext = {{16{imm16[15]}}, imm16};

    // SLL/SRL/SRA with rs and opcode all zero
    assign sh_hit = ({f.opcode, f.rs} == 11'd0) &&
                    (f.funct == FN_SLL || f.funct == FN_SRL || f.funct == FN_SRA);

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.aluop  = ALU_NOP;
        ctrl_o.alusel = SEL_NOP;
        ctrl_o.raddr1 = f.rs;
        ctrl_o.raddr2 = f.rt;
        ctrl_o.wd     = f.rd;
        r_hit         = 1'b0;
        i_hit         = 1'b0;

        case (f.opcode)
            OP_SPECIAL: begin
                if (f.shamt == 5'd0) begin
                    r_hit = 1'b1;
                    case (f.funct)
                        FN_OR:   {ctrl_o.aluop, ctrl_o.alusel} = {ALU_OR, SEL_LOGIC};
                        FN_AND:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_AND, SEL_LOGIC};
                        FN_XOR:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_XOR, SEL_LOGIC};
                        FN_NOR:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_NOR, SEL_LOGIC};
                        FN_SLLV: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLL, SEL_SHIFT};
                        FN_SRLV: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SRL, SEL_SHIFT};
                        FN_SRAV: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SRA, SEL_SHIFT};
                        FN_SLT:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLT, SEL_ARITH};
                        FN_SLTU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLTU, SEL_ARITH};
                        FN_ADD:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_ADD, SEL_ARITH};
                        FN_ADDU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_ADDU, SEL_ARITH};
                        FN_SUB:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SUB, SEL_ARITH};
                        FN_SUBU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SUBU, SEL_ARITH};
                        default: r_hit = 1'b0;    // mult, hi/lo moves etc.
                    endcase
                end
            end
            OP_ORI: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_OR, SEL_LOGIC};
                ctrl_o.imm                     = imm_zext;
            end
            OP_ANDI: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_AND, SEL_LOGIC};
                ctrl_o.imm                     = imm_zext;
            end
            OP_XORI: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_XOR, SEL_LOGIC};
                ctrl_o.imm                     = imm_zext;
            end
            OP_LUI: begin
                // rs is zero in a legal LUI, so an OR places the immediate
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_OR, SEL_LOGIC};
                ctrl_o.imm                     = {imm16, 16'h0000};
            end
            OP_SLTI: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_SLT, SEL_ARITH};
                ctrl_o.imm                     = imm_sext;
            end
            OP_SLTIU: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_SLTU, SEL_ARITH};
                ctrl_o.imm                     = imm_sext;  // sign-extended, compared unsigned
            end
            OP_ADDI: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_ADDI, SEL_ARITH};
                ctrl_o.imm                     = imm_sext;
            end
            OP_ADDIU: begin
                i_hit                          = 1'b1;
                {ctrl_o.aluop, ctrl_o.alusel}  = {ALU_ADDIU, SEL_ARITH};
                ctrl_o.imm                     = imm_sext;
            end
            default: begin
                i_hit = 1'b0;
            end
        endcase

        if (r_hit) begin
            ctrl_o.re1  = 1'b1;
            ctrl_o.re2  = 1'b1;
            ctrl_o.wreg = 1'b1;
        end

        if (i_hit) begin
            ctrl_o.re1  = 1'b1;
            ctrl_o.re2  = 1'b0;
            ctrl_o.wd   = f.rt;
            ctrl_o.wreg = 1'b1;
        end

        // shamt shifts win over the SPECIAL decode above
        if (sh_hit) begin
            ctrl_o.re1    = 1'b0;
            ctrl_o.re2    = 1'b1;
            ctrl_o.imm    = {27'd0, f.shamt};
            ctrl_o.wd     = f.rd;
            ctrl_o.wreg   = 1'b1;
            ctrl_o.alusel = SEL_SHIFT;
            case (f.funct)
                FN_SLL:  ctrl_o.aluop = ALU_SLL;
                FN_SRL:  ctrl_o.aluop = ALU_SRL;
                default: ctrl_o.aluop = ALU_SRA;
            endcase
        end
    end

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  id_ctrl_pkg::wr_port_t   wb_i,
    input  mips_isa_pkg::reg_addr_t raddr1_i,
    input  mips_isa_pkg::reg_addr_t raddr2_i,
    output mips_isa_pkg::word_t     rdata1_o,
    output mips_isa_pkg::word_t     rdata2_o
);
    import mips_isa_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.addr != '0)) begin   // $zero stays zero
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // one read port with write-through from writeback
    function automatic word_t read_port(input reg_addr_t addr);
        word_t rd;
        if (addr == '0) begin
            rd = '0;
        end else if (wb_i.we && (wb_i.addr == addr)) begin
            rd = wb_i.data;
        end else begin
            rd = regs[addr];
        end
        return rd;
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
    end

    always_comb begin
        rdata2_o = read_port(raddr2_i);
    end

endmodule

// File: logic/id_issue.sv
module id_issue (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  id_ctrl_pkg::id_ctrl_t ctrl_i,
    input  mips_isa_pkg::word_t   rdata1_i,
    input  mips_isa_pkg::word_t   rdata2_i,
    input  id_ctrl_pkg::wr_port_t ex_fwd_i,
    input  id_ctrl_pkg::wr_port_t mem_fwd_i,
    output id_ctrl_pkg::id_ex_t   id_ex_o
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    word_t  reg1;
    word_t  reg2;
    id_ex_t id_ex_d;

    // youngest result first, EX then MEM then the register file
    function automatic word_t pick_operand(
        input logic      ren,
        input reg_addr_t raddr,
        input word_t     rdata,
        input word_t     imm,
        input wr_port_t  ex_fwd,
        input wr_port_t  mem_fwd
    );
        word_t op;
        if (!ren) begin
            op = imm;
        end else if (ex_fwd.we && (ex_fwd.addr == raddr)) begin
            op = ex_fwd.data;
        end else if (mem_fwd.we && (mem_fwd.addr == raddr)) begin
            op = mem_fwd.data;
        end else begin
            op = rdata;
        end
        return op;
    endfunction

    assign reg1 = pick_operand(ctrl_i.re1, ctrl_i.raddr1, rdata1_i, ctrl_i.imm,
                               ex_fwd_i, mem_fwd_i);
    assign reg2 = pick_operand(ctrl_i.re2, ctrl_i.raddr2, rdata2_i, ctrl_i.imm,
                               ex_fwd_i, mem_fwd_i);

    assign id_ex_d = '{
        aluop:  ctrl_i.aluop,
        alusel: ctrl_i.alusel,
        reg1:   reg1,
        reg2:   reg2,
        wd:     ctrl_i.wd,
        wreg:   ctrl_i.wreg
    };

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;      // nop bundle with no write
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

// File: logic/id_stage.sv
module id_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  mips_isa_pkg::inst_t   inst_i,
    input  id_ctrl_pkg::wr_port_t ex_fwd_i,   // result now in EX
    input  id_ctrl_pkg::wr_port_t mem_fwd_i,  // result now in MEM
    input  id_ctrl_pkg::wr_port_t wb_i,
    output id_ctrl_pkg::id_ex_t   id_ex_o
);
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    id_ctrl_t ctrl;
    word_t    rdata1;
    word_t    rdata2;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_i     (wb_i),
        .raddr1_i (ctrl.raddr1),
        .raddr2_i (ctrl.raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    // operand forwarding and the ID/EX register
    id_issue u_issue (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ctrl_i    (ctrl),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .id_ex_o   (id_ex_o)
    );

endmodule

// File: bench/tb_id_stage.sv
module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_OPS      = 48;    // upper bound on writes plus issued words
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_OPS * 3) * CLK_PERIOD + 500;

    // words outside the kept set
    localparam opcode_t  OP_SPECIAL2 = 6'b011100;
    localparam funct_t   FN_MULT     = 6'b011000;
    localparam funct_t   FN_MFHI     = 6'b010000;
    localparam funct_t   FN_CLZ      = 6'b100000;
    localparam wr_port_t PORT_IDLE   = '0;

    logic     clk;
    logic     rst_n_i;
    inst_t    inst_i;
    wr_port_t ex_fwd_i;
    wr_port_t mem_fwd_i;
    wr_port_t wb_i;
    id_ex_t   id_ex_o;

    integer seed;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    word_t  shadow [NUM_REGS];    // expected register contents

    id_stage u_dut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst_i    (inst_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_i      (wb_i),
        .id_ex_o   (id_ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: stage did not finish");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic inst_t r_word(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input shamt_t sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t i_word(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                                     input imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wr_port_t make_port(input logic we, input reg_addr_t addr, input word_t data);
        wr_port_t p;
        p.we   = we;
        p.addr = addr;
        p.data = data;
        return p;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ctrl(input id_ex_t act, input aluop_t op, input alusel_t sel,
                              input reg_addr_t wd, input logic wreg);
        if (act.aluop !== op) begin
            $display("error: id_ex_o.aluop expected %h got %h", op, act.aluop);
            errors++;
        end
        if (act.alusel !== sel) begin
            $display("error: id_ex_o.alusel expected %h got %h", sel, act.alusel);
            errors++;
        end
        if (act.wd !== wd) begin
            $display("error: id_ex_o.wd expected %h got %h", wd, act.wd);
            errors++;
        end
        if (act.wreg !== wreg) begin
            $display("error: id_ex_o.wreg expected %h got %h", wreg, act.wreg);
            errors++;
        end
    endtask

    task automatic expect_bundle(input aluop_t op, input alusel_t sel, input word_t r1,
                                 input word_t r2, input reg_addr_t wd, input logic wreg);
        check_ctrl(id_ex_o, op, sel, wd, wreg);
        check_word("id_ex_o.reg1", r1, id_ex_o.reg1);
        check_word("id_ex_o.reg2", r2, id_ex_o.reg2);
    endtask

    // starts and ends 2 ns after an edge
    task automatic apply(input inst_t inst, input wr_port_t ex, input wr_port_t mem,
                         input wr_port_t wb);
        inst_i    = inst;
        ex_fwd_i  = ex;
        mem_fwd_i = mem;
        wb_i      = wb;
        @(posedge clk);
        #2;
        if (wb.we && wb.addr != '0) begin
            shadow[wb.addr] = wb.data;
        end
        ex_fwd_i  = PORT_IDLE;
        mem_fwd_i = PORT_IDLE;
        wb_i      = PORT_IDLE;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        apply(inst_i, PORT_IDLE, PORT_IDLE, make_port(1'b1, addr, data));
    endtask

    task automatic issue(input inst_t inst, input aluop_t op, input alusel_t sel,
                         input word_t r1, input word_t r2, input reg_addr_t wd, input logic wreg);
        apply(inst, PORT_IDLE, PORT_IDLE, PORT_IDLE);
        expect_bundle(op, sel, r1, r2, wd, wreg);
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        start   = errors;
        rst_n_i = 1'b0;
        inst_i  = r_word(FN_OR, 5'd5, 5'd6, 5'd7, 5'd0);
        wb_i    = make_port(1'b1, 5'd5, 32'hdead_beef);    // lost to the clear
        repeat (RESET_CYCLES / 2) @(posedge clk);
        #2;
        expect_bundle(ALU_NOP, SEL_NOP, '0, '0, 5'd0, 1'b0);
        repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        wb_i    = PORT_IDLE;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        expect_bundle(ALU_NOP, SEL_NOP, '0, '0, 5'd0, 1'b0);
        issue(r_word(FN_OR, 5'd5, 5'd6, 5'd7, 5'd0), ALU_OR, SEL_LOGIC, '0, '0, 5'd7, 1'b1);
        report_test("reset", start);
    endtask

    task automatic test_logic();
        int start;
        start = errors;
        for (int i = 1; i <= 4; i++) begin
            write_reg(reg_addr_t'(i), $random(seed));
        end
        issue(r_word(FN_OR, 5'd1, 5'd2, 5'd3, 5'd0), ALU_OR, SEL_LOGIC,
              shadow[1], shadow[2], 5'd3, 1'b1);
        issue(r_word(FN_AND, 5'd3, 5'd4, 5'd8, 5'd0), ALU_AND, SEL_LOGIC,
              shadow[3], shadow[4], 5'd8, 1'b1);
        issue(r_word(FN_XOR, 5'd4, 5'd1, 5'd9, 5'd0), ALU_XOR, SEL_LOGIC,
              shadow[4], shadow[1], 5'd9, 1'b1);
        issue(r_word(FN_NOR, 5'd2, 5'd3, 5'd10, 5'd0), ALU_NOR, SEL_LOGIC,
              shadow[2], shadow[3], 5'd10, 1'b1);
        issue(i_word(OP_ORI, 5'd1, 5'd5, 16'h8a5c), ALU_OR, SEL_LOGIC,
              shadow[1], 32'h0000_8a5c, 5'd5, 1'b1);
        issue(i_word(OP_ANDI, 5'd2, 5'd6, 16'hf00f), ALU_AND, SEL_LOGIC,
              shadow[2], 32'h0000_f00f, 5'd6, 1'b1);
        issue(i_word(OP_XORI, 5'd3, 5'd7, 16'h9999), ALU_XOR, SEL_LOGIC,
              shadow[3], 32'h0000_9999, 5'd7, 1'b1);
        issue(i_word(OP_LUI, 5'd0, 5'd8, 16'hbeef), ALU_OR, SEL_LOGIC,
              '0, 32'hbeef_0000, 5'd8, 1'b1);
        report_test("logic", start);
    endtask

    task automatic test_shift();
        int start;
        start = errors;
        // shamt lands in reg1
        issue(r_word(FN_SLL, 5'd0, 5'd2, 5'd11, 5'd7), ALU_SLL, SEL_SHIFT,
              32'd7, shadow[2], 5'd11, 1'b1);
        issue(r_word(FN_SRL, 5'd0, 5'd3, 5'd12, 5'd31), ALU_SRL, SEL_SHIFT,
              32'd31, shadow[3], 5'd12, 1'b1);
        issue(r_word(FN_SRA, 5'd0, 5'd4, 5'd13, 5'd1), ALU_SRA, SEL_SHIFT,
              32'd1, shadow[4], 5'd13, 1'b1);
        issue(r_word(FN_SLLV, 5'd1, 5'd2, 5'd12, 5'd0), ALU_SLL, SEL_SHIFT,
              shadow[1], shadow[2], 5'd12, 1'b1);
        issue(r_word(FN_SRLV, 5'd3, 5'd4, 5'd13, 5'd0), ALU_SRL, SEL_SHIFT,
              shadow[3], shadow[4], 5'd13, 1'b1);
        issue(r_word(FN_SRAV, 5'd4, 5'd1, 5'd14, 5'd0), ALU_SRA, SEL_SHIFT,
              shadow[4], shadow[1], 5'd14, 1'b1);
        report_test("shift", start);
    endtask

    task automatic test_arith();
        int start;
        start = errors;
        issue(r_word(FN_SLT, 5'd1, 5'd2, 5'd15, 5'd0), ALU_SLT, SEL_ARITH,
              shadow[1], shadow[2], 5'd15, 1'b1);
        issue(r_word(FN_SLTU, 5'd2, 5'd1, 5'd16, 5'd0), ALU_SLTU, SEL_ARITH,
              shadow[2], shadow[1], 5'd16, 1'b1);
        issue(r_word(FN_ADD, 5'd3, 5'd4, 5'd17, 5'd0), ALU_ADD, SEL_ARITH,
              shadow[3], shadow[4], 5'd17, 1'b1);
        issue(r_word(FN_ADDU, 5'd4, 5'd3, 5'd18, 5'd0), ALU_ADDU, SEL_ARITH,
              shadow[4], shadow[3], 5'd18, 1'b1);
        issue(r_word(FN_SUB, 5'd1, 5'd3, 5'd19, 5'd0), ALU_SUB, SEL_ARITH,
              shadow[1], shadow[3], 5'd19, 1'b1);
        issue(r_word(FN_SUBU, 5'd2, 5'd4, 5'd20, 5'd0), ALU_SUBU, SEL_ARITH,
              shadow[2], shadow[4], 5'd20, 1'b1);
        // negative immediates get an all-ones upper half
        issue(i_word(OP_SLTI, 5'd1, 5'd21, 16'hfff0), ALU_SLT, SEL_ARITH,
              shadow[1], 32'hffff_fff0, 5'd21, 1'b1);
        issue(i_word(OP_SLTIU, 5'd2, 5'd22, 16'h8000), ALU_SLTU, SEL_ARITH,
              shadow[2], 32'hffff_8000, 5'd22, 1'b1);
        issue(i_word(OP_ADDI, 5'd3, 5'd23, 16'hffff), ALU_ADDI, SEL_ARITH,
              shadow[3], 32'hffff_ffff, 5'd23, 1'b1);
        issue(i_word(OP_ADDIU, 5'd4, 5'd24, 16'h8001), ALU_ADDIU, SEL_ARITH,
              shadow[4], 32'hffff_8001, 5'd24, 1'b1);
        report_test("arith", start);
    endtask

    task automatic test_forward();
        int    start;
        inst_t inst;
        word_t va;
        word_t vb;
        word_t vc;
        word_t vd;
        start = errors;
        inst  = r_word(FN_OR, 5'd9, 5'd9, 5'd10, 5'd0);
        va    = $random(seed);
        vb    = $random(seed);
        vc    = $random(seed);
        vd    = $random(seed);
        write_reg(5'd9, $random(seed));
        apply(inst, make_port(1'b1, 5'd9, va), make_port(1'b1, 5'd9, vb),
              make_port(1'b1, 5'd9, vc));
        expect_bundle(ALU_OR, SEL_LOGIC, va, va, 5'd10, 1'b1);     // EX wins
        apply(inst, PORT_IDLE, make_port(1'b1, 5'd9, vb), make_port(1'b1, 5'd9, vd));
        expect_bundle(ALU_OR, SEL_LOGIC, vb, vb, 5'd10, 1'b1);     // MEM over writeback
        apply(inst, PORT_IDLE, PORT_IDLE, make_port(1'b1, 5'd9, vc));
        expect_bundle(ALU_OR, SEL_LOGIC, vc, vc, 5'd10, 1'b1);
        issue(inst, ALU_OR, SEL_LOGIC, shadow[9], shadow[9], 5'd10, 1'b1);
        // writes to $zero are dropped
        apply(r_word(FN_OR, 5'd0, 5'd0, 5'd11, 5'd0), PORT_IDLE, PORT_IDLE,
              make_port(1'b1, 5'd0, vd));
        expect_bundle(ALU_OR, SEL_LOGIC, '0, '0, 5'd11, 1'b1);
        issue(r_word(FN_OR, 5'd0, 5'd0, 5'd11, 5'd0), ALU_OR, SEL_LOGIC, '0, '0, 5'd11, 1'b1);
        // rt of an I-type is a destination and never an operand
        apply(i_word(OP_ORI, 5'd1, 5'd9, 16'h1234), make_port(1'b1, 5'd9, va),
              make_port(1'b1, 5'd9, vb), PORT_IDLE);
        expect_bundle(ALU_OR, SEL_LOGIC, shadow[1], 32'h0000_1234, 5'd9, 1'b1);
        report_test("forward", start);
    endtask

    task automatic test_unsupported();
        int start;
        start = errors;
        issue(r_word(FN_MULT, 5'd1, 5'd2, 5'd13, 5'd0), ALU_NOP, SEL_NOP, '0, '0, 5'd13, 1'b0);
        issue(r_word(FN_MFHI, 5'd0, 5'd0, 5'd14, 5'd0), ALU_NOP, SEL_NOP, '0, '0, 5'd14, 1'b0);
        issue({OP_SPECIAL2, 5'd3, 5'd3, 5'd15, 5'd0, FN_CLZ}, ALU_NOP, SEL_NOP,
              '0, '0, 5'd15, 1'b0);
        issue(r_word(FN_ADD, 5'd1, 5'd2, 5'd16, 5'd3), ALU_NOP, SEL_NOP, '0, '0, 5'd16, 1'b0);
        report_test("unsupported", start);
    endtask

    initial begin
        seed         = 32'hd779;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n_i      = 1'b0;
        inst_i       = '0;
        ex_fwd_i     = PORT_IDLE;
        mem_fwd_i    = PORT_IDLE;
        wb_i         = PORT_IDLE;

        test_reset();
        test_logic();
        test_shift();
        test_arith();
        test_forward();
        test_unsupported();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
logic/mips_isa_pkg.sv
logic/id_ctrl_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/id_issue.sv
logic/id_stage.sv
bench/tb_id_stage.sv
